// ==== rtl/mmio_pkg.sv ====
//////////////////////////////////////////////////
// MMIO front end shared definitions
//////////////////////////////////////////////////

package mmio_pkg;

  // Host request, bit 0 is the MSB throughout
  typedef struct packed {
    logic        valid;
    logic        cfg;
    logic        read;
    logic        doubleword;
    logic [0:23] address;
    logic        address_parity;
    logic [0:63] data;
    logic        data_parity;
  } mmio_in_t;

  typedef struct packed {
    logic        ack;
    logic [0:63] data;
    logic        data_parity;
  } mmio_out_t;

  typedef enum logic [1:0] {
    OP_CFG_READ,
    OP_CFG_WRITE,
    OP_REG_READ,
    OP_REG_WRITE
  } mmio_op_t;

  typedef struct packed {
    mmio_op_t    op;
    logic [0:23] address;
    logic [0:63] data;
    logic        doubleword;
  } mmio_cmd_t;

  // Accelerator descriptor, eight 64-bit words
  typedef struct packed {
    logic [0:15] num_ints_per_process;
    logic [0:15] num_of_processes;
    logic [0:15] num_of_afu_crs;
    logic [0:15] req_prog_model;
    logic [0:63] reserved_1;
    logic [0:7]  reserved_2;
    logic [0:55] afu_cr_len;
    logic [0:63] afu_cr_offset;
    logic [0:5]  reserved_3;
    logic        psa_per_process_required;
    logic        psa_required;
    logic [0:55] psa_length;
    logic [0:63] psa_offset;
    logic [0:7]  reserved_4;
    logic [0:55] afu_eb_len;
    logic [0:63] afu_eb_offset;
  } afu_desc_t;

  // Dedicated process model, one process, one config record
  localparam afu_desc_t AFU_DESC = '{
    num_ints_per_process     : 16'h0000,
    num_of_processes         : 16'h0001,
    num_of_afu_crs           : 16'h0001,
    req_prog_model           : 16'h8010,
    reserved_1               : 64'h0,
    reserved_2               : 8'h00,
    afu_cr_len               : 56'h1,
    afu_cr_offset            : 64'h0000_0000_0000_0100,
    reserved_3               : 6'b00_0000,
    psa_per_process_required : 1'b0,
    psa_required             : 1'b1,
    psa_length               : 56'h0,
    psa_offset               : 64'h0,
    reserved_4               : 8'h00,
    afu_eb_len               : 56'h0,
    afu_eb_offset            : 64'h0
  };

  localparam logic [0:23] ALGO_REQUEST = 24'h000000;
  localparam logic [0:23] ALGO_STATUS  = 24'h000002;
  localparam logic [0:23] ERROR_REG    = 24'h000004;

  localparam int CMD_QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W     = $clog2(CMD_QUEUE_DEPTH);

  // Bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [0:63] value);
    return ~^value;
  endfunction

  // Word index is the doubleword address modulo 8
  function automatic logic [0:63] read_afu_descriptor(input logic [0:22] word_addr);
    logic [0:511] flat;
    flat = AFU_DESC;
    return flat[64 * word_addr[20:22] +: 64];
  endfunction

endpackage

// ==== rtl/mmio_decode.sv ====
//////////////////////////////////////////////////
// MMIO request decoder and parity check
//////////////////////////////////////////////////

module mmio_decode (
  input  logic                clock,
  input  logic                rstn,
  input  mmio_pkg::mmio_in_t  mmio_in,
  output logic                push,
  output mmio_pkg::mmio_cmd_t cmd,
  output logic [0:1]          mmio_errors
);

  import mmio_pkg::*;

  logic      in_valid;
  mmio_in_t  in_q;
  mmio_op_t  op;
  logic      addr_bad;
  logic      data_bad;
  logic      dec_valid;
  mmio_cmd_t dec_cmd;
  logic      addr_err;
  logic      data_err;

  //////////////////////////////////////////////////
  // Host request capture
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      in_valid <= 1'b0;
    end else begin
      in_valid <= mmio_in.valid;
    end
  end

  always_ff @(posedge clock) begin
    in_q <= mmio_in;
  end

  // Opcode from cfg and read
  always_comb begin
    case ({in_q.cfg, in_q.read})
      2'b11:   op = OP_CFG_READ;
      2'b10:   op = OP_CFG_WRITE;
      2'b01:   op = OP_REG_READ;
      default: op = OP_REG_WRITE;
    endcase
  end

  // Data parity only means something on writes
  assign addr_bad = in_q.address_parity != odd_parity({40'd0, in_q.address});
  assign data_bad = !in_q.read && (in_q.data_parity != odd_parity(in_q.data));

  //////////////////////////////////////////////////
  // Decode and output stages
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      dec_valid   <= 1'b0;
      addr_err    <= 1'b0;
      data_err    <= 1'b0;
      push        <= 1'b0;
      mmio_errors <= 2'b00;
    end else begin
      dec_valid   <= in_valid;
      addr_err    <= in_valid && addr_bad;
      data_err    <= in_valid && data_bad;
      push        <= dec_valid;
      mmio_errors <= {data_err, addr_err};
    end
  end

  always_ff @(posedge clock) begin
    dec_cmd <= '{op: op, address: in_q.address, data: in_q.data, doubleword: in_q.doubleword};
    cmd     <= dec_cmd;
  end

  // Error pulse belongs to the request sampled three edges earlier
  a_err_after_valid: assert property (@(posedge clock) disable iff (!rstn)
    (|mmio_errors) |-> $past(mmio_in.valid, 3));

endmodule

// ==== rtl/mmio_cmd_queue.sv ====
//////////////////////////////////////////////////
// Command FIFO with four-phase head handshake
//////////////////////////////////////////////////

module mmio_cmd_queue (
  input  logic                clock,
  input  logic                rstn,
  input  logic                push,
  input  mmio_pkg::mmio_cmd_t cmd,
  output logic                req,
  output mmio_pkg::mmio_cmd_t cmd_head,
  input  logic                ack
);

  import mmio_pkg::*;

  typedef enum logic [1:0] {Q_IDLE, Q_REQ, Q_WAIT_LOW} queue_state_t;

  queue_state_t           state;
  mmio_cmd_t              mem [CMD_QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_PTR_W:0]   count;
  logic                   pop;
  logic                   has_entry;

  assign pop       = (state == Q_REQ) && ack;
  assign has_entry = (count != '0) || push;
  assign req       = (state == Q_REQ);
  assign cmd_head  = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + QUEUE_PTR_W'(1);
      if (pop) rd_ptr <= rd_ptr + QUEUE_PTR_W'(1);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Handshake FSM for the head entry
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= Q_IDLE;
    end else begin
      case (state)
        Q_IDLE:     if (has_entry) state <= Q_REQ;
        Q_REQ:      if (ack) state <= Q_WAIT_LOW;
        Q_WAIT_LOW: if (!ack) state <= has_entry ? Q_REQ : Q_IDLE;
        default:    state <= Q_IDLE;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clock) disable iff (!rstn)
    push |-> (count < CMD_QUEUE_DEPTH));

  a_head_stable: assert property (@(posedge clock) disable iff (!rstn)
    req |=> (!req || $stable(cmd_head)));

  a_req_after_ack_low: assert property (@(posedge clock) disable iff (!rstn)
    $rose(req) |-> !ack);

endmodule

// ==== rtl/mmio_reg_exec.sv ====
//////////////////////////////////////////////////
// MMIO register executor and host response
//////////////////////////////////////////////////

module mmio_reg_exec (
  input  logic                clock,
  input  logic                rstn,
  input  logic                req,
  input  mmio_pkg::mmio_cmd_t cmd_head,
  output logic                ack,
  input  logic [0:63]         report_errors,
  input  logic [0:63]         algorithm_status,
  output logic [0:63]         algorithm_requests,
  output logic                errors_ack,
  output logic                status_ack,
  output mmio_pkg::mmio_out_t mmio_out
);

  import mmio_pkg::*;

  typedef enum logic [1:0] {E_IDLE, E_EXEC, E_ACK, E_WAIT_LOW} exec_state_t;

  exec_state_t state;
  logic [0:63] status_q;
  logic [0:63] errors_q;
  logic [0:63] desc_word;
  logic [0:63] rd_data;
  logic        fire;
  logic        status_hit;
  logic        errors_hit;
  logic        request_hit;
  logic        resp_ack;
  logic [0:63] resp_data;
  logic        resp_parity;

  // Register inputs sampled every cycle
  always_ff @(posedge clock) begin
    status_q <= algorithm_status;
    errors_q <= report_errors;
  end

  //////////////////////////////////////////////////
  // Read data selection
  //////////////////////////////////////////////////

  assign desc_word   = read_afu_descriptor(cmd_head.address[0:22]);
  assign status_hit  = (cmd_head.op == OP_REG_READ) && (cmd_head.address == ALGO_STATUS);
  assign errors_hit  = (cmd_head.op == OP_REG_READ) && (cmd_head.address == ERROR_REG);
  assign request_hit = (cmd_head.op == OP_REG_WRITE) && (cmd_head.address == ALGO_REQUEST);

  always_comb begin
    rd_data = 64'h0;
    if (cmd_head.op == OP_CFG_READ) begin
      if (cmd_head.doubleword) begin
        rd_data = desc_word;
      end else if (cmd_head.address[23]) begin
        rd_data = {desc_word[32:63], desc_word[32:63]};
      end else begin
        rd_data = {desc_word[0:31], desc_word[0:31]};
      end
    end else if (status_hit) begin
      rd_data = status_q;
    end else if (errors_hit) begin
      rd_data = errors_q;
    end
  end

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= E_IDLE;
      ack   <= 1'b0;
    end else begin
      case (state)
        E_IDLE: if (req) state <= E_EXEC;
        E_EXEC: begin
          ack   <= 1'b1;
          state <= E_ACK;
        end
        E_ACK:  state <= E_WAIT_LOW;
        E_WAIT_LOW: begin
          // Hold ack until the queue drops req
          if (!req) begin
            ack   <= 1'b0;
            state <= E_IDLE;
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  assign fire = (state == E_EXEC);

  // Host side pulses, registered with the rise of ack
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_ack           <= 1'b0;
      algorithm_requests <= 64'h0;
      errors_ack         <= 1'b0;
      status_ack         <= 1'b0;
    end else begin
      resp_ack           <= fire;
      algorithm_requests <= (fire && request_hit) ? cmd_head.data : 64'h0;
      errors_ack         <= fire && errors_hit && (|errors_q);
      status_ack         <= fire && status_hit && (|status_q);
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      resp_data   <= rd_data;
      resp_parity <= odd_parity(rd_data);
    end
  end

  assign mmio_out = '{ack: resp_ack, data: resp_data, data_parity: resp_parity};

  a_ack_one_cycle: assert property (@(posedge clock) disable iff (!rstn)
    mmio_out.ack |=> !mmio_out.ack);

endmodule

// ==== rtl/mmio_ctrl_top.sv ====
//////////////////////////////////////////////////
// MMIO front end top level
//////////////////////////////////////////////////

module mmio_ctrl_top (
  input  logic                clock,
  input  logic                rstn,
  input  mmio_pkg::mmio_in_t  mmio_in,
  output mmio_pkg::mmio_out_t mmio_out,
  output logic [0:1]          mmio_errors,
  input  logic [0:63]         report_errors,
  input  logic [0:63]         algorithm_status,
  output logic [0:63]         algorithm_requests,
  output logic                errors_ack,
  output logic                status_ack
);

  import mmio_pkg::*;

  logic      push;
  mmio_cmd_t cmd;
  logic      req;
  mmio_cmd_t cmd_head;
  logic      ack;

  mmio_decode u_decode (
    .clock       (clock),
    .rstn        (rstn),
    .mmio_in     (mmio_in),
    .push        (push),
    .cmd         (cmd),
    .mmio_errors (mmio_errors)
  );

  mmio_cmd_queue u_queue (
    .clock    (clock),
    .rstn     (rstn),
    .push     (push),
    .cmd      (cmd),
    .req      (req),
    .cmd_head (cmd_head),
    .ack      (ack)
  );

  mmio_reg_exec u_exec (
    .clock              (clock),
    .rstn               (rstn),
    .req                (req),
    .cmd_head           (cmd_head),
    .ack                (ack),
    .report_errors      (report_errors),
    .algorithm_status   (algorithm_status),
    .algorithm_requests (algorithm_requests),
    .errors_ack         (errors_ack),
    .status_ack         (status_ack),
    .mmio_out           (mmio_out)
  );

endmodule

// ==== bench/tb_clock.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////

module tb_clock (
  output logic clock,
  output logic rstn
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 4;

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  // Released just after the fourth rising edge
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    rstn = 1'b1;
  end

endmodule

// ==== bench/mmio_ctrl_tb.sv ====
//////////////////////////////////////////////////
// MMIO front end testbench
//////////////////////////////////////////////////

module mmio_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import mmio_pkg::*;

  localparam int NUM_REQUESTS   = 50;
  localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 20 + 200;

  typedef struct packed {
    logic [0:63] data;
    logic [0:63] algo;
    logic        status_pulse;
    logic        errors_pulse;
  } exp_resp_t;

  logic        clock;
  logic        rstn;
  mmio_in_t    mmio_in;
  mmio_out_t   mmio_out;
  logic [0:1]  mmio_errors;
  logic [0:63] report_errors;
  logic [0:63] algorithm_status;
  logic [0:63] algorithm_requests;
  logic        errors_ack;
  logic        status_ack;

  exp_resp_t   exp_q[$];
  exp_resp_t   exp_head;
  logic        exp_pending;
  logic [0:1]  err_now;
  logic [0:1]  err_d1;
  logic [0:1]  err_d2;
  logic [0:1]  err_d3;
  int          seed;
  int          issued;
  int          answered;
  int          value_errors;
  int          protocol_errors;

  tb_clock u_clock (
    .clock (clock),
    .rstn  (rstn)
  );

  mmio_ctrl_top DUT (
    .clock              (clock),
    .rstn               (rstn),
    .mmio_in            (mmio_in),
    .mmio_out           (mmio_out),
    .mmio_errors        (mmio_errors),
    .report_errors      (report_errors),
    .algorithm_status   (algorithm_status),
    .algorithm_requests (algorithm_requests),
    .errors_ack         (errors_ack),
    .status_ack         (status_ack)
  );

  //////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////

  // Descriptor words as laid out by the struct
  function automatic logic [0:63] desc_word(input int idx);
    case (idx % 8)
      0:       return 64'h0000_0001_0001_8010;
      2:       return 64'h0000_0000_0000_0001;
      3:       return 64'h0000_0000_0000_0100;
      4:       return 64'h0100_0000_0000_0000;
      default: return 64'h0;
    endcase
  endfunction

  function automatic exp_resp_t response(input logic [0:63] data, input logic [0:63] algo,
                                         input logic status_pulse, input logic errors_pulse);
    return '{data: data, algo: algo, status_pulse: status_pulse, errors_pulse: errors_pulse};
  endfunction

  function automatic logic [0:63] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic flag_mismatch(input string msg);
    value_errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic flag_protocol(input string msg);
    protocol_errors++;
    $display("Protocol error at %0t ns: %s", $time, msg);
  endtask

  task automatic refresh_head();
    exp_pending <= (exp_q.size() != 0);
    exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
  endtask

  //////////////////////////////////////////////////
  // Host model
  //////////////////////////////////////////////////

  // flips[0] corrupts data parity, flips[1] address parity
  task automatic send_request(input logic cfg, input logic read, input logic dw,
                              input logic [0:23] addr, input logic [0:63] data,
                              input logic [0:1] flips, input exp_resp_t expected);
    mmio_in_t request;
    while (exp_q.size() >= CMD_QUEUE_DEPTH) begin
      @(posedge clock);
      #1;
      mmio_in.valid = 1'b0;
      err_now       = 2'b00;
    end
    @(posedge clock);
    #1;
    request = '{valid: 1'b1, cfg: cfg, read: read, doubleword: dw, address: addr,
                address_parity: (~^addr) ^ flips[1], data: data,
                data_parity: (~^data) ^ flips[0]};
    mmio_in = request;
    err_now = {flips[0] && !read, flips[1]};
    exp_q.push_back(expected);
    refresh_head();
    issued++;
  endtask

  task automatic wait_idle();
    @(posedge clock);
    #1;
    mmio_in.valid = 1'b0;
    err_now       = 2'b00;
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #1;
    end
    repeat (2) @(posedge clock);
    #1;
  endtask

  task automatic set_sources(input logic [0:63] status, input logic [0:63] errors);
    @(posedge clock);
    #1;
    algorithm_status = status;
    report_errors    = errors;
  endtask

  // Responses leave the queue on the edge that samples the ack
  always @(posedge clock) begin
    if (rstn && mmio_out.ack) begin
      answered++;
      if (exp_q.size() != 0) begin
        exp_q.delete(0);
      end
      refresh_head();
    end
  end

  // Parity report is due three edges after the request edge
  always @(posedge clock) begin
    err_d1 <= mmio_in.valid ? err_now : 2'b00;
    err_d2 <= err_d1;
    err_d3 <= err_d2;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_resp_expected: assert property (@(posedge clock) disable iff (!rstn)
    mmio_out.ack |-> exp_pending)
    else flag_protocol("acknowledge arrived with no request outstanding");

  a_resp_data: assert property (@(posedge clock) disable iff (!rstn)
    mmio_out.ack |-> (mmio_out.data == exp_head.data))
    else flag_mismatch($sformatf("read data %h, expected %h", mmio_out.data, exp_head.data));

  a_resp_parity: assert property (@(posedge clock) disable iff (!rstn)
    mmio_out.ack |-> ^{mmio_out.data, mmio_out.data_parity})
    else flag_mismatch("response data parity is not odd");

  a_algo_pulse: assert property (@(posedge clock) disable iff (!rstn)
    algorithm_requests == (mmio_out.ack ? exp_head.algo : 64'h0))
    else flag_mismatch($sformatf("algorithm_requests %h unexpected", algorithm_requests));

  a_status_pulse: assert property (@(posedge clock) disable iff (!rstn)
    status_ack == (mmio_out.ack && exp_head.status_pulse))
    else flag_mismatch("status_ack pulse wrong");

  a_errors_pulse: assert property (@(posedge clock) disable iff (!rstn)
    errors_ack == (mmio_out.ack && exp_head.errors_pulse))
    else flag_mismatch("errors_ack pulse wrong");

  a_parity_report: assert property (@(posedge clock) disable iff (!rstn)
    mmio_errors == err_d3)
    else flag_mismatch($sformatf("mmio_errors %b, expected %b", mmio_errors, err_d3));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic read_descriptor();
    logic [0:63] word;
    for (int w = 0; w < 8; w++) begin
      send_request(1'b1, 1'b1, 1'b1, 24'(2 * w), 64'h0, 2'b00,
                   response(desc_word(w), 64'h0, 1'b0, 1'b0));
    end
    // Address bit 23 set picks the low half
    for (int w = 0; w < 8; w++) begin
      word = desc_word(w);
      send_request(1'b1, 1'b1, 1'b0, 24'(2 * w), 64'h0, 2'b00,
                   response({word[0:31], word[0:31]}, 64'h0, 1'b0, 1'b0));
      send_request(1'b1, 1'b1, 1'b0, 24'(2 * w + 1), 64'h0, 2'b00,
                   response({word[32:63], word[32:63]}, 64'h0, 1'b0, 1'b0));
    end
    // Word 12 wraps to word 4
    send_request(1'b1, 1'b1, 1'b1, 24'h000018, 64'h0, 2'b00,
                 response(desc_word(12), 64'h0, 1'b0, 1'b0));
    wait_idle();
  endtask

  task automatic write_requests();
    logic [0:63] value;
    for (int i = 0; i < 4; i++) begin
      value = random_word();
      send_request(1'b0, 1'b0, 1'b1, ALGO_REQUEST, value, 2'b00,
                   response(64'h0, value, 1'b0, 1'b0));
    end
    send_request(1'b0, 1'b0, 1'b1, ALGO_STATUS, random_word(), 2'b00, '0);
    send_request(1'b0, 1'b0, 1'b1, 24'h000010, random_word(), 2'b00, '0);
    send_request(1'b1, 1'b0, 1'b1, ALGO_REQUEST, random_word(), 2'b00, '0);
    wait_idle();
  endtask

  task automatic read_registers();
    logic [0:63] value;
    value = random_word() | 64'h1;
    set_sources(value, 64'h0);
    send_request(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 2'b00,
                 response(value, 64'h0, 1'b1, 1'b0));
    send_request(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 2'b00, '0);
    wait_idle();
    set_sources(64'h0, value);
    send_request(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 2'b00, '0);
    send_request(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 2'b00,
                 response(value, 64'h0, 1'b0, 1'b1));
    send_request(1'b0, 1'b1, 1'b1, 24'h000006, 64'h0, 2'b00, '0);
    send_request(1'b0, 1'b1, 1'b1, 24'h000100, 64'h0, 2'b00, '0);
    wait_idle();
  endtask

  task automatic inject_parity_errors();
    logic [0:63] value;
    value = random_word();
    send_request(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 2'b01,
                 response(report_errors, 64'h0, 1'b0, report_errors != 64'h0));
    wait_idle();
    send_request(1'b0, 1'b0, 1'b1, ALGO_REQUEST, value, 2'b10,
                 response(64'h0, value, 1'b0, 1'b0));
    wait_idle();
    send_request(1'b0, 1'b0, 1'b1, 24'h000008, value, 2'b11, '0);
    wait_idle();
    // Reads carry no data parity check
    send_request(1'b1, 1'b1, 1'b1, 24'h000000, value, 2'b10,
                 response(desc_word(0), 64'h0, 1'b0, 1'b0));
    wait_idle();
  endtask

  task automatic send_bursts();
    logic [0:63] status;
    logic [0:63] errors;
    logic [0:63] value;
    logic [0:63] word;
    status = random_word();
    errors = random_word();
    value  = random_word();
    word   = desc_word(0);
    set_sources(status, errors);
    send_request(1'b1, 1'b1, 1'b1, 24'h000006, 64'h0, 2'b00, response(desc_word(3), 0, 0, 0));
    send_request(1'b0, 1'b0, 1'b1, ALGO_REQUEST, value, 2'b00, response(0, value, 0, 0));
    send_request(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 2'b00,
                 response(status, 64'h0, status != 64'h0, 1'b0));
    send_request(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 2'b00,
                 response(errors, 64'h0, 1'b0, errors != 64'h0));
    wait_idle();
    send_request(1'b1, 1'b1, 1'b0, 24'h000001, 64'h0, 2'b00,
                 response({word[32:63], word[32:63]}, 64'h0, 1'b0, 1'b0));
    send_request(1'b0, 1'b1, 1'b1, 24'h00000a, 64'h0, 2'b00, '0);
    send_request(1'b0, 1'b0, 1'b1, 24'h00000c, value, 2'b00, '0);
    send_request(1'b1, 1'b1, 1'b1, 24'h000008, 64'h0, 2'b00, response(desc_word(4), 0, 0, 0));
    wait_idle();
  endtask

  initial begin
    seed             = 32'hd055;
    issued           = 0;
    answered         = 0;
    value_errors     = 0;
    protocol_errors  = 0;
    mmio_in          = '0;
    err_now          = 2'b00;
    algorithm_status = 64'h0;
    report_errors    = 64'h0;
    refresh_head();
    @(posedge rstn);
    @(posedge clock);
    #1;
    read_descriptor();
    write_requests();
    read_registers();
    inject_parity_errors();
    send_bursts();
    if (answered != issued) begin
      flag_protocol($sformatf("%0d requests issued but %0d answered", issued, answered));
    end
    $display("Summary: %0d value errors, %0d protocol errors, %0d requests",
             value_errors, protocol_errors, issued);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout: run did not finish within %0d cycles, %0d of %0d requests answered",
             TIMEOUT_CYCLES, answered, issued);
    $display("Summary: %0d value errors, %0d protocol errors, %0d requests",
             value_errors, protocol_errors, issued);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== mmio_ctrl.f ====
rtl/mmio_pkg.sv
rtl/mmio_decode.sv
rtl/mmio_cmd_queue.sv
rtl/mmio_reg_exec.sv
rtl/mmio_ctrl_top.sv
bench/tb_clock.sv
bench/mmio_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the MMIO front end

VERILATOR ?= verilator
TOP       ?= mmio_ctrl_tb
FILELIST  ?= mmio_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# Rebuilt only when a source, the file list or this Makefile changes
$(BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx '$(PASS_TEXT)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
